// ==== hdl/cdma_pkg.sv ====
// cdma package holding bus widths, AXI and DMA codes and the channel structs
`default_nettype none

package cdma_pkg;

    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;
    localparam int BURST_SIZE = 2;
    localparam int LEN_W = 16;
    localparam int TAG_W = 8;
    localparam int MAX_BURST_LEN = 16;
    localparam int MAX_BURST_BYTES = MAX_BURST_LEN * STRB_W;
    localparam int CYCLE_CNT_W = 11;
    localparam int STATUS_FIFO_AW = 3;
    localparam int OUT_FIFO_AW = 4;

    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_EXOKAY = 2'b01;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    localparam logic [3:0] ERR_NONE = 4'd0;
    localparam logic [3:0] ERR_RD_SLVERR = 4'd4;
    localparam logic [3:0] ERR_RD_DECERR = 4'd5;
    localparam logic [3:0] ERR_WR_SLVERR = 4'd6;
    localparam logic [3:0] ERR_WR_DECERR = 4'd7;

    typedef struct packed {
        logic [ADDR_W-1:0] src_addr;
        logic [ADDR_W-1:0] dst_addr;
        logic [LEN_W-1:0]  len;
        logic [TAG_W-1:0]  tag;
    } desc_req_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [3:0]       error;
    } desc_sts_t;

    // shared by AR and AW
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
    } axi_ax_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } axi_r_t;

    // one write burst
    typedef struct packed {
        logic [ADDR_W-1:0]      addr;
        logic [CYCLE_CNT_W-1:0] cycles;
        logic [BURST_SIZE-1:0]  last_offset;
        logic                   last_transfer;
        logic [TAG_W-1:0]       tag;
    } burst_cmd_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [1:0]       rresp;
        logic             last;
    } status_ent_t;

endpackage

`default_nettype wire

// ==== hdl/cdma_burst_split.sv ====
// cdma burst splitter, takes descriptors and issues write burst commands and AR bursts
`default_nettype none

module cdma_burst_split import cdma_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  desc_req_t  desc_req,
    input  logic       desc_req_valid,
    output logic       desc_req_ready,
    input  logic       enable,
    output axi_ax_t    ar,
    output logic       ar_valid,
    input  logic       ar_ready,
    output burst_cmd_t cmd,
    output logic       cmd_valid,
    input  logic       cmd_ready,
    output logic       start,
    input  logic       slot_free
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_REQ
    } state_t;

    state_t            state;
    logic [ADDR_W-1:0] read_addr;
    logic [ADDR_W-1:0] write_addr;
    logic [LEN_W-1:0]  op_count;
    logic [LEN_W-1:0]  axi_count;
    logic [TAG_W-1:0]  tag;
    logic [LEN_W-1:0]  wr_room;
    logic [LEN_W-1:0]  rd_room;
    logic [LEN_W-1:0]  wr_chunk;
    logic [LEN_W-1:0]  rd_chunk;

    // bytes left before the next 4 KB page
    assign wr_room = LEN_W'(13'h1000 - {1'b0, write_addr[11:0]});
    assign rd_room = LEN_W'(13'h1000 - {1'b0, read_addr[11:0]});

    always_comb begin
        wr_chunk = op_count;
        if (wr_chunk > LEN_W'(MAX_BURST_BYTES)) begin
            wr_chunk = LEN_W'(MAX_BURST_BYTES);
        end
        if (wr_chunk > wr_room) begin
            wr_chunk = wr_room;
        end

        rd_chunk = axi_count;
        if (rd_chunk > LEN_W'(MAX_BURST_BYTES)) begin
            rd_chunk = LEN_W'(MAX_BURST_BYTES);
        end
        if (rd_chunk > rd_room) begin
            rd_chunk = rd_room;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            desc_req_ready <= 1'b0;
            cmd_valid <= 1'b0;
            ar_valid <= 1'b0;
            start <= 1'b0;
        end else begin
            desc_req_ready <= 1'b0;
            start <= 1'b0;
            if (cmd_ready) begin
                cmd_valid <= 1'b0;
            end
            if (ar_ready) begin
                ar_valid <= 1'b0;
            end

            case (state)
                ST_IDLE: begin
                    if (desc_req_ready && desc_req_valid) begin
                        // both addresses forced to word alignment
                        read_addr <= {desc_req.src_addr[ADDR_W-1:BURST_SIZE],
                                      {BURST_SIZE{1'b0}}};
                        write_addr <= {desc_req.dst_addr[ADDR_W-1:BURST_SIZE],
                                       {BURST_SIZE{1'b0}}};
                        op_count <= desc_req.len;
                        tag <= desc_req.tag;
                        state <= ST_START;
                    end else begin
                        desc_req_ready <= enable && slot_free && !cmd_valid;
                    end
                end
                ST_START: begin
                    // size the next write burst
                    if (!cmd_valid && slot_free) begin
                        cmd.addr <= write_addr;
                        cmd.cycles <= CYCLE_CNT_W'((wr_chunk - 1'b1) >> BURST_SIZE);
                        cmd.last_offset <= wr_chunk[BURST_SIZE-1:0];
                        cmd.last_transfer <= op_count == wr_chunk;
                        cmd.tag <= tag;
                        cmd_valid <= 1'b1;
                        start <= 1'b1;
                        write_addr <= write_addr + ADDR_W'(wr_chunk);
                        op_count <= op_count - wr_chunk;
                        axi_count <= wr_chunk;
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    // read bursts covering the write chunk
                    if (!ar_valid) begin
                        ar.addr <= read_addr;
                        ar.len <= 8'((rd_chunk - 1'b1) >> BURST_SIZE);
                        ar_valid <= 1'b1;
                        read_addr <= read_addr + ADDR_W'(rd_chunk);
                        axi_count <= axi_count - rd_chunk;
                        if (axi_count == rd_chunk) begin
                            state <= (op_count != '0) ? ST_START : ST_IDLE;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cdma_write_engine.sv ====
// cdma write engine, issues AW per burst command and turns R beats into W beats
`default_nettype none

module cdma_write_engine import cdma_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  burst_cmd_t  cmd,
    input  logic        cmd_valid,
    output logic        cmd_ready,
    output axi_ax_t     aw,
    output logic        aw_valid,
    input  logic        aw_ready,
    input  axi_r_t      r,
    input  logic        r_valid,
    output logic        r_ready,
    input  logic        room,
    output axi_w_t      beat,
    output logic        beat_valid,
    output status_ent_t ent,
    output logic        ent_push
);

    typedef enum logic {
        ST_IDLE,
        ST_WRITE
    } state_t;

    state_t                 state;
    logic [CYCLE_CNT_W-1:0] cycles_left;
    logic [BURST_SIZE-1:0]  last_offset;
    logic                   last_transfer;
    logic [TAG_W-1:0]       tag;
    logic [1:0]             rresp_reg;
    logic [1:0]             rresp_new;
    logic                   r_fire;
    logic                   last_beat;

    assign cmd_ready = (state == ST_IDLE) && !aw_valid;
    assign r_fire = r_valid && r_ready;
    assign last_beat = cycles_left == '0;

    // sticky read error, SLVERR outranks DECERR
    always_comb begin
        rresp_new = rresp_reg;
        if (r_fire && r.resp != RESP_OKAY && r.resp != RESP_EXOKAY &&
                rresp_reg != RESP_SLVERR) begin
            rresp_new = r.resp;
        end
    end

    always_comb begin
        beat.data = r.data;
        beat.strb = '1;
        beat.last = last_beat;
        if (last_beat && last_offset != '0) begin
            beat.strb = ~({STRB_W{1'b1}} << last_offset);
        end
        beat_valid = r_fire;

        ent.tag = tag;
        ent.rresp = rresp_new;
        ent.last = last_transfer;
        ent_push = r_fire && last_beat;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            aw_valid <= 1'b0;
            r_ready <= 1'b0;
            rresp_reg <= RESP_OKAY;
        end else begin
            if (aw_ready) begin
                aw_valid <= 1'b0;
            end
            // cleared once the descriptor's final burst is done
            rresp_reg <= (ent_push && last_transfer) ? RESP_OKAY : rresp_new;

            case (state)
                ST_IDLE: begin
                    if (cmd_valid && cmd_ready) begin
                        aw.addr <= cmd.addr;
                        aw.len <= 8'(cmd.cycles);
                        aw_valid <= 1'b1;
                        cycles_left <= cmd.cycles;
                        last_offset <= cmd.last_offset;
                        last_transfer <= cmd.last_transfer;
                        tag <= cmd.tag;
                        r_ready <= room;
                        state <= ST_WRITE;
                    end
                end
                default: begin
                    r_ready <= room;
                    if (r_fire) begin
                        cycles_left <= cycles_left - 1'b1;
                        if (last_beat) begin
                            r_ready <= 1'b0;
                            state <= ST_IDLE;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cdma_out_fifo.sv ====
// cdma W channel FIFO with half-full throttle and a registered W output
`default_nettype none

module cdma_out_fifo import cdma_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  axi_w_t beat,
    input  logic   beat_valid,
    output logic   room,
    output axi_w_t w,
    output logic   w_valid,
    input  logic   w_ready
);

    axi_w_t                 mem [2**OUT_FIFO_AW];
    logic [OUT_FIFO_AW:0]   wr_ptr;
    logic [OUT_FIFO_AW:0]   rd_ptr;
    logic [OUT_FIFO_AW:0]   level;
    logic                   full;
    logic                   empty;

    assign full = wr_ptr == (rd_ptr ^ {1'b1, {OUT_FIFO_AW{1'b0}}});
    assign empty = wr_ptr == rd_ptr;
    assign level = wr_ptr - rd_ptr;

    always_ff @(posedge clk) begin
        if (beat_valid && !full) begin
            mem[wr_ptr[OUT_FIFO_AW-1:0]] <= beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            room <= 1'b0;
            w_valid <= 1'b0;
        end else begin
            // below half full leaves margin for beats already in flight
            room <= level < (OUT_FIFO_AW + 1)'(2**(OUT_FIFO_AW - 1));

            if (beat_valid && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end

            if (w_ready) begin
                w_valid <= 1'b0;
            end
            if (!empty && (!w_valid || w_ready)) begin
                w <= mem[rd_ptr[OUT_FIFO_AW-1:0]];
                w_valid <= 1'b1;
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cdma_status_track.sv ====
// cdma status tracker, pairs B responses with bursts and reports descriptor status
`default_nettype none

module cdma_status_track import cdma_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  status_ent_t ent,
    input  logic        ent_push,
    input  logic        start,
    input  logic [1:0]  b_resp,
    input  logic        b_valid,
    output logic        b_ready,
    output logic        slot_free,
    output desc_sts_t   desc_sts,
    output logic        desc_sts_valid
);

    status_ent_t             mem [2**STATUS_FIFO_AW];
    status_ent_t             head;
    logic [STATUS_FIFO_AW:0] wr_ptr;
    logic [STATUS_FIFO_AW:0] rd_ptr;
    logic [STATUS_FIFO_AW:0] active_cnt;
    logic [STATUS_FIFO_AW:0] active_next;
    logic [1:0]              bresp_reg;
    logic [1:0]              bresp_new;
    logic [3:0]              err_code;
    logic                    b_fire;
    logic                    empty;

    assign empty = wr_ptr == rd_ptr;
    assign b_fire = b_valid && b_ready;
    assign head = mem[rd_ptr[STATUS_FIFO_AW-1:0]];

    always_comb begin
        bresp_new = bresp_reg;
        if (b_fire && b_resp != RESP_OKAY && b_resp != RESP_EXOKAY &&
                bresp_reg != RESP_SLVERR) begin
            bresp_new = b_resp;
        end
        active_next = active_cnt + (STATUS_FIFO_AW + 1)'(start)
            - (STATUS_FIFO_AW + 1)'(b_fire);

        // read errors rank above write errors
        if (head.rresp == RESP_SLVERR) begin
            err_code = ERR_RD_SLVERR;
        end else if (head.rresp == RESP_DECERR) begin
            err_code = ERR_RD_DECERR;
        end else if (bresp_new == RESP_SLVERR) begin
            err_code = ERR_WR_SLVERR;
        end else if (bresp_new == RESP_DECERR) begin
            err_code = ERR_WR_DECERR;
        end else begin
            err_code = ERR_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (ent_push) begin
            mem[wr_ptr[STATUS_FIFO_AW-1:0]] <= ent;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            active_cnt <= '0;
            slot_free <= 1'b1;
            b_ready <= 1'b0;
            bresp_reg <= RESP_OKAY;
            desc_sts_valid <= 1'b0;
        end else begin
            desc_sts_valid <= 1'b0;
            bresp_reg <= bresp_new;
            active_cnt <= active_next;
            slot_free <= active_next < (STATUS_FIFO_AW + 1)'(2**STATUS_FIFO_AW);
            b_ready <= !empty && !b_fire;

            if (ent_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (b_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
                if (head.last) begin
                    desc_sts.tag <= head.tag;
                    desc_sts.error <= err_code;
                    desc_sts_valid <= 1'b1;
                    bresp_reg <= RESP_OKAY;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cdma_top.sv ====
// cdma top level, AXI4 central DMA copying one descriptor at a time
`default_nettype none

module cdma_top import cdma_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  desc_req_t  desc_req,
    input  logic       desc_req_valid,
    output logic       desc_req_ready,
    output desc_sts_t  desc_sts,
    output logic       desc_sts_valid,
    input  logic       enable,
    output axi_ax_t    ar,
    output logic       ar_valid,
    input  logic       ar_ready,
    input  axi_r_t     r,
    input  logic       r_valid,
    output logic       r_ready,
    output axi_ax_t    aw,
    output logic       aw_valid,
    input  logic       aw_ready,
    output axi_w_t     w,
    output logic       w_valid,
    input  logic       w_ready,
    input  logic [1:0] b_resp,
    input  logic       b_valid,
    output logic       b_ready
);

    burst_cmd_t  cmd;
    logic        cmd_valid;
    logic        cmd_ready;
    axi_w_t      beat;
    logic        beat_valid;
    logic        room;
    status_ent_t ent;
    logic        ent_push;
    logic        start;
    logic        slot_free;

    cdma_burst_split u_split (
        .clk(clk),
        .rst(rst),
        .desc_req(desc_req),
        .desc_req_valid(desc_req_valid),
        .desc_req_ready(desc_req_ready),
        .enable(enable),
        .ar(ar),
        .ar_valid(ar_valid),
        .ar_ready(ar_ready),
        .cmd(cmd),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .start(start),
        .slot_free(slot_free)
    );

    cdma_write_engine u_engine (
        .clk(clk),
        .rst(rst),
        .cmd(cmd),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .aw(aw),
        .aw_valid(aw_valid),
        .aw_ready(aw_ready),
        .r(r),
        .r_valid(r_valid),
        .r_ready(r_ready),
        .room(room),
        .beat(beat),
        .beat_valid(beat_valid),
        .ent(ent),
        .ent_push(ent_push)
    );

    cdma_out_fifo u_out_fifo (
        .clk(clk),
        .rst(rst),
        .beat(beat),
        .beat_valid(beat_valid),
        .room(room),
        .w(w),
        .w_valid(w_valid),
        .w_ready(w_ready)
    );

    cdma_status_track u_status (
        .clk(clk),
        .rst(rst),
        .ent(ent),
        .ent_push(ent_push),
        .start(start),
        .b_resp(b_resp),
        .b_valid(b_valid),
        .b_ready(b_ready),
        .slot_free(slot_free),
        .desc_sts(desc_sts),
        .desc_sts_valid(desc_sts_valid)
    );

endmodule

`default_nettype wire

// ==== verif/cdma_mem_model.sv ====
// cdma memory model, AXI4 slave with read and write error windows and ready throttling
`default_nettype none

module cdma_mem_model import cdma_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        throttle,
    input  wire logic        b_hold,
    input  wire logic [31:0] rnd,
    input  wire axi_ax_t     ar,
    input  wire logic        ar_valid,
    output logic             ar_ready,
    output axi_r_t           r,
    output logic             r_valid,
    input  wire logic        r_ready,
    input  wire axi_ax_t     aw,
    input  wire logic        aw_valid,
    output logic             aw_ready,
    input  wire axi_w_t      w,
    input  wire logic        w_valid,
    output logic             w_ready,
    output logic [1:0]       b_resp,
    output logic             b_valid,
    input  wire logic        b_ready
);

    logic [7:0]  mem [0:65535];
    axi_ax_t     ar_q[$];
    axi_ax_t     aw_q[$];
    axi_w_t      w_q[$];
    logic [1:0]  b_q[$];
    logic        r_taken;
    logic        b_taken;
    logic        wr_err;
    int          rd_cnt;
    int          wr_cnt;

    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 8'(i) ^ 8'(i >> 8);
        end
        ar_ready = 1'b0;
        aw_ready = 1'b0;
        w_ready = 1'b0;
        r = '0;
        r_valid = 1'b0;
        b_resp = RESP_OKAY;
        b_valid = 1'b0;
        r_taken = 1'b0;
        b_taken = 1'b0;
        wr_err = 1'b0;
        rd_cnt = 0;
        wr_cnt = 0;
    end

    // handshakes seen on the rising edge, acted on at the falling edge
    always @(posedge clk) begin
        if (ar_valid && ar_ready) ar_q.push_back(ar);
        if (aw_valid && aw_ready) aw_q.push_back(aw);
        if (w_valid && w_ready) w_q.push_back(w);
        if (r_valid && r_ready) r_taken = 1'b1;
        if (b_valid && b_ready) b_taken = 1'b1;
    end

    always @(negedge clk) begin
        logic [15:0] a;
        axi_w_t      wb;
        if (rst) begin
            ar_q.delete();
            aw_q.delete();
            w_q.delete();
            b_q.delete();
            r_valid = 1'b0;
            b_valid = 1'b0;
            r_taken = 1'b0;
            b_taken = 1'b0;
            rd_cnt = 0;
            wr_cnt = 0;
            wr_err = 1'b0;
        end else begin
            if (r_taken) begin
                r_valid = 1'b0;
                r_taken = 1'b0;
                if (r.last) begin
                    void'(ar_q.pop_front());
                    rd_cnt = 0;
                end else begin
                    rd_cnt++;
                end
            end
            if (!r_valid && ar_q.size() > 0 && (!throttle || rnd[3])) begin
                a = ar_q[0].addr + 16'(rd_cnt * 4);
                r.data = {mem[16'(a + 3)], mem[16'(a + 2)], mem[16'(a + 1)], mem[a]};
                r.resp = (a >= 16'he000) ? RESP_SLVERR : RESP_OKAY;
                r.last = rd_cnt == int'(ar_q[0].len);
                r_valid = 1'b1;
            end
            // W beats wait here until their AW has been accepted
            while (w_q.size() > 0 && aw_q.size() > 0) begin
                wb = w_q.pop_front();
                a = aw_q[0].addr + 16'(wr_cnt * 4);
                if (a >= 16'hf000) begin
                    wr_err = 1'b1;
                end else begin
                    for (int k = 0; k < STRB_W; k++) begin
                        if (wb.strb[k]) mem[16'(a + k)] = wb.data[8*k +: 8];
                    end
                end
                if (wr_cnt == int'(aw_q[0].len)) begin
                    b_q.push_back(wr_err ? RESP_DECERR : RESP_OKAY);
                    void'(aw_q.pop_front());
                    wr_cnt = 0;
                    wr_err = 1'b0;
                end else begin
                    wr_cnt++;
                end
            end
            if (b_taken) begin
                b_valid = 1'b0;
                b_taken = 1'b0;
            end
            // responses queue up while b_hold is high
            if (!b_valid && b_q.size() > 0 && !b_hold) begin
                b_resp = b_q.pop_front();
                b_valid = 1'b1;
            end
        end
        ar_ready = !throttle || rnd[0];
        aw_ready = !throttle || rnd[1];
        w_ready = !throttle || rnd[2];
    end

endmodule

`default_nettype wire

// ==== verif/cdma_props.sv ====
// cdma handshake properties, bound to the top level
`default_nettype none

module cdma_props import cdma_pkg::*; (
    input wire logic      clk,
    input wire logic      rst,
    input wire desc_req_t desc_req,
    input wire logic      desc_req_valid,
    input wire logic      desc_req_ready,
    input wire logic      desc_sts_valid,
    input wire axi_ax_t   ar,
    input wire logic      ar_valid,
    input wire logic      ar_ready,
    input wire axi_ax_t   aw,
    input wire logic      aw_valid,
    input wire logic      aw_ready,
    input wire axi_w_t    w,
    input wire logic      w_valid,
    input wire logic      w_ready,
    input wire logic      beat_valid
);

    logic [5:0] held;

    // W beats inside the FIFO and its output register
    always_ff @(posedge clk) begin
        if (rst) begin
            held <= '0;
        end else begin
            held <= held + 6'(beat_valid) - 6'(w_valid && w_ready);
        end
    end

    a_desc_hold: assert property (@(posedge clk) disable iff (rst)
        desc_req_valid && !desc_req_ready |=> desc_req_valid && $stable(desc_req))
        else $error("descriptor request dropped or changed before acceptance");

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
        else $error("AR request dropped or changed before acceptance");

    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else $error("AW request dropped or changed before acceptance");

    a_w_hold: assert property (@(posedge clk) disable iff (rst)
        w_valid && !w_ready |=> w_valid && $stable(w))
        else $error("W beat dropped or changed before acceptance");

    a_sts_pulse: assert property (@(posedge clk) disable iff (rst)
        desc_sts_valid |=> !desc_sts_valid)
        else $error("status valid held longer than one cycle");

    // the half-full throttle must leave a free entry for every R beat in flight
    a_r_throttle: assert property (@(posedge clk) disable iff (rst)
        beat_valid |-> held < 6'(2**OUT_FIFO_AW) + 6'(w_valid))
        else $error("R beat arrived while the W FIFO was full");

endmodule

bind cdma_top cdma_props u_props (.*);

`default_nettype wire

// ==== verif/tb_cdma.sv ====
// cdma testbench, random and directed copies checked against a byte-level reference
`default_nettype none

module tb_cdma;
    import cdma_pkg::*;

    localparam int NUM_DESC = 34;

    typedef struct {
        int         src;
        int         dst;
        int         len;
        logic [7:0] tag;
        logic [3:0] err;
    } exp_t;

    logic        clk;
    logic        rst;
    desc_req_t   desc_req;
    logic        desc_req_valid;
    logic        desc_req_ready;
    desc_sts_t   desc_sts;
    logic        desc_sts_valid;
    logic        enable;
    axi_ax_t     ar;
    logic        ar_valid;
    logic        ar_ready;
    axi_r_t      r;
    logic        r_valid;
    logic        r_ready;
    axi_ax_t     aw;
    logic        aw_valid;
    logic        aw_ready;
    axi_w_t      w;
    logic        w_valid;
    logic        w_ready;
    logic [1:0]  b_resp;
    logic        b_valid;
    logic        b_ready;
    logic        throttle;
    logic        b_hold;
    logic [31:0] thr_rnd;
    logic [31:0] seed;
    logic [7:0]  shadow [0:65535];
    exp_t        exp_q[$];
    int          err_count;
    int          done_count;
    int          test_count;
    int          wbytes;
    logic [7:0]  next_tag;

    cdma_top uut (.*);

    cdma_mem_model u_mem (.rnd(thr_rnd), .*);

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // byte expected at a after descriptor e, old is the previous content
    function automatic logic [7:0] expected_byte(exp_t e, int a, logic [7:0] old);
        int s;
        if (a >= e.dst && a < e.dst + e.len) begin
            s = e.src + (a - e.dst);
            return 8'(s) ^ 8'(s >> 8);
        end
        return old;
    endfunction

    // read errors outrank write errors
    function automatic logic [3:0] expected_error(int src, int dst, int len);
        if (((src + len - 1) & ~3) >= 'he000) return ERR_RD_SLVERR;
        if (dst + len - 1 >= 'hf000) return ERR_WR_DECERR;
        return ERR_NONE;
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %h expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic wait_accept();
        @(posedge clk);
        while (!desc_req_ready) @(posedge clk);
        @(negedge clk);
        desc_req_valid = 1'b0;
    endtask

    task automatic drive_desc(input int src, input int dst, input int len);
        exp_t e;
        e.src = src;
        e.dst = dst;
        e.len = len;
        e.tag = next_tag;
        e.err = expected_error(src, dst, len);
        exp_q.push_back(e);
        @(negedge clk);
        desc_req.src_addr = 16'(src);
        desc_req.dst_addr = 16'(dst);
        desc_req.len = 16'(len);
        desc_req.tag = next_tag;
        desc_req_valid = 1'b1;
        next_tag++;
    endtask

    task automatic send_desc(input int src, input int dst, input int len);
        drive_desc(src, dst, len);
        wait_accept();
    endtask

    task automatic finish_test(input string name);
        while (exp_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
        test_count++;
        $display("test %0d %s done, errors so far %0d", test_count, name, err_count);
    endtask

    task automatic random_copies(input int n);
        int len;
        int src;
        int dst;
        for (int i = 0; i < n; i++) begin
            seed = xorshift32(seed);
            len = int'(seed % 300) + 1;
            seed = xorshift32(seed);
            src = int'(seed % 'h3000) & ~3;
            seed = xorshift32(seed);
            dst = 'h4000 + (int'(seed % 'h6000) & ~3);
            send_desc(src, dst, len);
            while (exp_q.size() != 0) @(posedge clk);
        end
    endtask

    // compares each status and the destination bytes in descriptor order
    always @(posedge clk) begin
        exp_t       e;
        logic [7:0] eb;
        if (!rst && desc_sts_valid) begin
            if (exp_q.size() == 0) begin
                $display("unexpected status with tag %0d at %0t", desc_sts.tag, $time);
                err_count++;
            end else begin
                e = exp_q.pop_front();
                check_eq(32'(desc_sts.tag), 32'(e.tag), "status tag");
                check_eq(32'(desc_sts.error), 32'(e.err), "status error");
                for (int a = e.dst; a < e.dst + e.len + 4 && a < 'hf000; a++) begin
                    eb = expected_byte(e, a, shadow[a]);
                    shadow[a] = eb;
                    check_eq(32'(u_mem.mem[a]), 32'(eb), "destination byte");
                end
                done_count++;
            end
        end
    end

    // burst limits on every AR and AW, and write byte count
    always @(posedge clk) begin
        if (ar_valid && ar_ready) begin
            check_eq(32'(ar.len <= 15), 1, "AR burst length");
            check_eq(32'(32'(ar.addr[11:0]) + (32'(ar.len) + 1) * 4 <= 4096), 1, "AR 4 KB");
        end
        if (aw_valid && aw_ready) begin
            check_eq(32'(aw.len <= 15), 1, "AW burst length");
            check_eq(32'(32'(aw.addr[11:0]) + (32'(aw.len) + 1) * 4 <= 4096), 1, "AW 4 KB");
        end
        if (w_valid && w_ready) wbytes += $countones(w.strb);
        thr_rnd <= xorshift32(thr_rnd);
    end

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (NUM_DESC * 200 + 20) @(posedge clk);
        $display("timeout: run still busy after %0d cycles", NUM_DESC * 200 + 20);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        rst = 1'b1;
        desc_req = '0;
        desc_req_valid = 1'b0;
        enable = 1'b1;
        throttle = 1'b0;
        b_hold = 1'b0;
        seed = 32'hc62b0ce9;
        thr_rnd = xorshift32(32'hc62b0ce9);
        err_count = 0;
        done_count = 0;
        test_count = 0;
        wbytes = 0;
        next_tag = 8'h10;
        for (int i = 0; i < 65536; i++) begin
            shadow[i] = 8'(i) ^ 8'(i >> 8);
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        random_copies(8);
        finish_test("random aligned copies");

        wbytes = 0;
        send_desc('h0fe8, 'h5fd0, 200);
        while (exp_q.size() != 0) @(posedge clk);
        check_eq(32'(wbytes), 200, "write byte total");
        finish_test("4 KB crossing");

        send_desc('he000, 'h6000, 40);
        send_desc('h0100, 'h6100, 40);
        send_desc('h0200, 'hf100, 40);
        send_desc('he100, 'hf200, 40);
        finish_test("error codes");

        throttle = 1'b1;
        random_copies(8);
        finish_test("back-pressure");
        throttle = 1'b0;

        @(negedge clk);
        enable = 1'b0;
        drive_desc('h0300, 'h6200, 24);
        repeat (20) begin
            @(posedge clk);
            check_eq(32'(desc_req_ready), 0, "ready while disabled");
            check_eq(32'(ar_valid), 0, "AR while disabled");
        end
        @(negedge clk);
        enable = 1'b1;
        wait_accept();
        finish_test("enable gating");

        // B held back so eight bursts stay in flight and block the ninth
        @(negedge clk);
        b_hold = 1'b1;
        for (int i = 0; i < 8; i++) begin
            send_desc('h0400 + i * 'h40, 'h7000 + i * 'h100, 8 + i * 2);
        end
        drive_desc('h0400 + 8 * 'h40, 'h7000 + 8 * 'h100, 8 + 8 * 2);
        repeat (40) begin
            @(posedge clk);
            check_eq(32'(desc_req_ready), 0, "ready at in-flight limit");
        end
        @(negedge clk);
        b_hold = 1'b0;
        wait_accept();
        for (int i = 9; i < 12; i++) begin
            send_desc('h0400 + i * 'h40, 'h7000 + i * 'h100, 8 + i * 2);
        end
        finish_test("in-flight limit");

        $display("tests %0d, descriptors %0d, errors %0d", test_count, done_count, err_count);
        if (err_count == 0 && done_count == NUM_DESC) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cdma.f ====
hdl/cdma_pkg.sv
hdl/cdma_burst_split.sv
hdl/cdma_write_engine.sv
hdl/cdma_out_fifo.sv
hdl/cdma_status_track.sv
hdl/cdma_top.sv
verif/cdma_mem_model.sv
verif/cdma_props.sv
verif/tb_cdma.sv
